//--- logic/align_geom_pkg.sv
package align_geom_pkg;

	// score matrix coordinates, 64 by 64
	localparam int POS_WIDTH = 6;

	// tile edge and in-tile offset width
	localparam int TILE_LEN       = 8;
	localparam int TILE_IDX_WIDTH = 3;

	typedef logic [POS_WIDTH-1:0] pos_t;           // matrix row or column
	typedef logic [TILE_IDX_WIDTH-1:0] tile_idx_t; // offset inside the tile

	// x is the row, y the column
	// also used as tile anchor (row base, column base)
	typedef struct packed {
		pos_t x;
		pos_t y;
	} start_req_t;

	// one column read from the direction memory
	typedef struct packed {
		pos_t col;       // matrix column
		pos_t first_row; // row of entry 0
	} col_req_t;

endpackage

//--- logic/trace_code_pkg.sv
package trace_code_pkg;

	import align_geom_pkg::*;

	// h_src codes of a direction entry
	localparam logic [1:0] H_STOP = 2'd0;
	localparam logic [1:0] H_DIAG = 2'd1;
	localparam logic [1:0] H_LEFT = 2'd2; // came from the left gap
	localparam logic [1:0] H_UP   = 2'd3; // came from the up gap

	typedef struct packed {
		logic [1:0] h_src;
		logic       e_ext; // left gap keeps extending
		logic       f_ext; // up gap keeps extending
	} dir_entry_t;

	// entry k is row first_row+k
	typedef dir_entry_t [TILE_LEN-1:0] column_t;

	// all entries stop, fills columns outside the matrix
	localparam column_t STOP_COLUMN = '0;

	// M diagonal, I left, D up
	typedef enum logic [1:0] {
		M,
		I,
		D,
		STOP
	} trace_sym_t;

	typedef enum logic [1:0] {
		IDLE,
		FILL,
		WALK,
		FINISH
	} walk_state_t;

endpackage

//--- logic/column_fetcher.sv
module column_fetcher import align_geom_pkg::*, trace_code_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// refill request from the walker
	input  logic       refill_valid,
	output logic       refill_ready,
	input  start_req_t refill_anchor,
	// column requests to the direction memory
	output logic       mem_req_valid,
	input  logic       mem_req_ready,
	output col_req_t   mem_req,
	// column responses, in request order
	input  logic       mem_rsp_valid,
	output logic       mem_rsp_ready,
	input  column_t    mem_rsp,
	// tile write port
	output logic       wr_en,
	output tile_idx_t  wr_col,
	output column_t    wr_data,
	output logic       tile_loaded
);

	start_req_t         anchor_q;
	tile_idx_t          cnt;      // column offset being fetched
	logic               active;
	logic               wait_rsp; // request accepted, response pending
	logic               loaded_q;
	logic               last_col;
	logic               skip_col;
	logic [POS_WIDTH:0] col_sum;

	assign refill_ready = !active;

	// one extra bit to catch columns past the matrix edge
	assign col_sum  = {1'b0, anchor_q.y} + {{(POS_WIDTH-TILE_IDX_WIDTH+1){1'b0}}, cnt};
	assign skip_col = col_sum[POS_WIDTH];
	assign last_col = (cnt == tile_idx_t'(TILE_LEN-1));

	assign mem_req_valid = active && !wait_rsp && !skip_col;
	assign mem_req       = '{col: col_sum[POS_WIDTH-1:0], first_row: anchor_q.x};
	assign mem_rsp_ready = wait_rsp;

	// response write, or stop fill when the column does not exist
	assign wr_en   = (wait_rsp && mem_rsp_valid) || (active && !wait_rsp && skip_col);
	assign wr_col  = cnt;
	assign wr_data = wait_rsp ? mem_rsp : STOP_COLUMN;

	assign tile_loaded = loaded_q;

	always_ff @(posedge clk) begin
		if (refill_valid && refill_ready)
			anchor_q <= refill_anchor;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active   <= 1'b0;
			wait_rsp <= 1'b0;
			cnt      <= '0;
			loaded_q <= 1'b0;
		end else begin
			loaded_q <= 1'b0;
			if (refill_valid && refill_ready) begin
				active <= 1'b1;
				cnt    <= '0;
			end
			if (mem_req_valid && mem_req_ready)
				wait_rsp <= 1'b1;
			if (wr_en) begin
				wait_rsp <= 1'b0;
				cnt      <= cnt + tile_idx_t'(1);
				if (last_col) begin
					active   <= 1'b0;
					loaded_q <= 1'b1; // tile readable from next cycle
				end
			end
		end
	end

	// a stalled request must not change under the memory
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
		else $error("column request changed while stalled");

endmodule

//--- logic/tile_store.sv
module tile_store import align_geom_pkg::*, trace_code_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// column-wide write from the fetcher
	input  logic       wr_en,
	input  tile_idx_t  wr_col,
	input  column_t    wr_data,
	// single entry read for the walker
	input  tile_idx_t  rd_x,  // row offset
	input  tile_idx_t  rd_y,  // column offset
	output dir_entry_t rd_entry
);

	// one column_t per tile column, rows packed inside
	column_t tile [TILE_LEN];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < TILE_LEN; k++)
				tile[k] <= STOP_COLUMN;
		end else if (wr_en) begin
			tile[wr_col] <= wr_data;
		end
	end

	// combinational read, sees a write one cycle later
	assign rd_entry = tile[rd_y][rd_x];

	// an unknown index would corrupt a random column
	a_wr_col_known: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !$isunknown(wr_col))
		else $error("tile write with unknown column index");

endmodule

//--- logic/traceback_walker.sv
module traceback_walker import align_geom_pkg::*, trace_code_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// start handshake
	input  logic       start_valid,
	output logic       start_ready,
	input  start_req_t start_req,
	// tile refill to the fetcher
	output logic       refill_valid,
	input  logic       refill_ready,
	output start_req_t refill_anchor,
	input  logic       tile_loaded,
	// tile read
	output tile_idx_t  rd_x,
	output tile_idx_t  rd_y,
	input  dir_entry_t rd_entry,
	// symbol output
	output logic       sym_valid,
	input  logic       sym_ready,
	output trace_sym_t sym,
	output logic       done,
	output logic       busy
);

	walk_state_t state;
	pos_t        pos_x;
	pos_t        pos_y;
	pos_t        base_x;  // tile top row
	pos_t        base_y;  // tile left column
	pos_t        nxt_x;
	pos_t        nxt_y;
	trace_sym_t  prev;    // gap state, only M, I or D
	trace_sym_t  cur_sym;
	trace_sym_t  nxt_prev;
	logic        move_x;
	logic        move_y;
	logic        stop_walk;
	logic        leave_tile;
	logic        step_en;

	// tile top-left for a bottom-right cell, clamped at the matrix edge
	function automatic pos_t tile_base(pos_t p);
		return (p > pos_t'(TILE_LEN-1)) ? p - pos_t'(TILE_LEN-1) : '0;
	endfunction

	assign rd_x = tile_idx_t'(pos_x - base_x);
	assign rd_y = tile_idx_t'(pos_y - base_y);

	// symbol rule
	always_comb begin
		cur_sym  = M;
		nxt_prev = M;
		case (prev)
			I: begin
				cur_sym  = I;
				nxt_prev = rd_entry.e_ext ? I : M;
			end
			D: begin
				cur_sym  = D;
				nxt_prev = rd_entry.f_ext ? D : M;
			end
			default: begin
				case (rd_entry.h_src)
					H_STOP:  cur_sym = STOP;
					H_DIAG:  cur_sym = M;
					H_LEFT:  cur_sym = I;
					default: cur_sym = D;
				endcase
				nxt_prev = cur_sym; // gap opens in the emitted direction
			end
		endcase
	end

	assign move_x = (cur_sym == M) || (cur_sym == D);
	assign move_y = (cur_sym == M) || (cur_sym == I);

	// end on stop or on a move off the matrix
	assign stop_walk = (cur_sym == STOP) ||
		(move_x && (pos_x == '0)) ||
		(move_y && (pos_y == '0));

	assign nxt_x = move_x ? pos_x - pos_t'(1) : pos_x;
	assign nxt_y = move_y ? pos_y - pos_t'(1) : pos_y;

	assign leave_tile = (nxt_x < base_x) || (nxt_y < base_y);

	// output slot free or freeing this cycle
	assign step_en = (state == WALK) && (!sym_valid || sym_ready);

	assign start_ready   = (state == IDLE);
	assign done          = (state == FINISH);
	assign busy          = (state == FILL) || (state == WALK);
	assign refill_anchor = '{x: base_x, y: base_y};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= IDLE;
			pos_x        <= '0;
			pos_y        <= '0;
			base_x       <= '0;
			base_y       <= '0;
			prev         <= M;
			refill_valid <= 1'b0;
			sym_valid    <= 1'b0;
		end else begin
			if (sym_valid && sym_ready)
				sym_valid <= 1'b0;
			if (refill_valid && refill_ready)
				refill_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (start_valid) begin
						pos_x        <= start_req.x;
						pos_y        <= start_req.y;
						base_x       <= tile_base(start_req.x);
						base_y       <= tile_base(start_req.y);
						prev         <= M;
						refill_valid <= 1'b1;
						state        <= FILL;
					end
				end
				FILL: begin
					if (tile_loaded)
						state <= WALK;
				end
				WALK: begin
					if (step_en) begin
						if (stop_walk) begin
							state <= FINISH;
						end else begin
							sym_valid <= 1'b1;
							pos_x     <= nxt_x;
							pos_y     <= nxt_y;
							prev      <= nxt_prev;
							if (leave_tile) begin // new tile ends at the new cell
								base_x       <= tile_base(nxt_x);
								base_y       <= tile_base(nxt_y);
								refill_valid <= 1'b1;
								state        <= FILL;
							end
						end
					end
				end
				default: state <= IDLE; // FINISH lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (step_en && !stop_walk)
			sym <= cur_sym;
	end

	// held symbol must survive back-pressure
	a_sym_stable: assert property (@(posedge clk) disable iff (!rst_n)
		sym_valid && !sym_ready |=> sym_valid && $stable(sym))
		else $error("symbol changed before it was accepted");

endmodule

//--- logic/traceback_top.sv
module traceback_top import align_geom_pkg::*, trace_code_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// start from the host
	input  logic       start_valid,
	output logic       start_ready,
	input  start_req_t start_req,
	// direction memory
	output logic       mem_req_valid,
	input  logic       mem_req_ready,
	output col_req_t   mem_req,
	input  logic       mem_rsp_valid,
	output logic       mem_rsp_ready,
	input  column_t    mem_rsp,
	// alignment symbols to the host
	output logic       sym_valid,
	input  logic       sym_ready,
	output trace_sym_t sym,
	output logic       done,
	output logic       busy
);

	logic       refill_valid;
	logic       refill_ready;
	start_req_t refill_anchor;
	logic       tile_loaded;
	logic       wr_en;
	tile_idx_t  wr_col;
	column_t    wr_data;
	tile_idx_t  rd_x;
	tile_idx_t  rd_y;
	dir_entry_t rd_entry;

	column_fetcher fetcher_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.refill_valid  (refill_valid),
		.refill_ready  (refill_ready),
		.refill_anchor (refill_anchor),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req       (mem_req),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_ready (mem_rsp_ready),
		.mem_rsp       (mem_rsp),
		.wr_en         (wr_en),
		.wr_col        (wr_col),
		.wr_data       (wr_data),
		.tile_loaded   (tile_loaded)
	);

	tile_store tile_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_col   (wr_col),
		.wr_data  (wr_data),
		.rd_x     (rd_x),
		.rd_y     (rd_y),
		.rd_entry (rd_entry)
	);

	traceback_walker walker_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.start_valid   (start_valid),
		.start_ready   (start_ready),
		.start_req     (start_req),
		.refill_valid  (refill_valid),
		.refill_ready  (refill_ready),
		.refill_anchor (refill_anchor),
		.tile_loaded   (tile_loaded),
		.rd_x          (rd_x),
		.rd_y          (rd_y),
		.rd_entry      (rd_entry),
		.sym_valid     (sym_valid),
		.sym_ready     (sym_ready),
		.sym           (sym),
		.done          (done),
		.busy          (busy)
	);

endmodule

//--- tests/dir_memory_model.sv
module dir_memory_model import align_geom_pkg::*, trace_code_pkg::*; (
	input  logic       clk,
	input  logic [1:0] pattern,   // 0 diagonal, 1 left, 2 stop cell, 3 random
	input  logic       req_valid,
	output logic       req_ready,
	input  col_req_t   req,
	output logic       rsp_valid,
	input  logic       rsp_ready,
	output column_t    rsp
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAT_LEN   = 1 << POS_WIDTH;
	localparam int STOP_CELL = 30; // stop entry of pattern 2 sits at (30,30)

	dir_entry_t matrix [MAT_LEN][MAT_LEN]; // [row][column]
	int         seed    = 32'h6d25_f1dc;
	int         delay   = 0;
	logic       holding = 1'b0;   // a request is being served
	logic       rsp_on  = 1'b0;
	logic       req_hs  = 1'b0;   // handshakes taken at the last rising edge
	logic       rsp_hs  = 1'b0;
	col_req_t   req_q   = '0;
	column_t    rsp_q   = '0;

	// multiplicative hash over the whole cell address
	function automatic dir_entry_t pattern_entry(logic [1:0] code, int r, int c);
		logic [31:0] h;
		dir_entry_t  e;
		h = (32'(r) * 32'd64 + 32'(c) + 32'd1) * 32'd2654435761;
		h = h ^ (h >> 15);
		e.e_ext = h[25];
		e.f_ext = h[24];
		case (code)
			2'd0:    e.h_src = H_DIAG;
			2'd1:    e.h_src = H_LEFT;
			2'd2:    e.h_src = (r == STOP_CELL && c == STOP_CELL) ? H_STOP : H_DIAG;
			default: e.h_src = (h[31:28] == 4'd0) ? H_STOP :
				((h[27:26] == 2'd0) ? H_DIAG : h[27:26]); // diagonal twice as likely
		endcase
		return e;
	endfunction

	function automatic column_t read_column(col_req_t r);
		column_t c;
		int      row;
		for (int k = 0; k < TILE_LEN; k++) begin
			row = int'(r.first_row) + k;
			c[k] = (row < MAT_LEN) ? matrix[row][r.col] : dir_entry_t'('0);
		end
		return c;
	endfunction

	always_comb begin
		for (int r = 0; r < MAT_LEN; r++)
			for (int c = 0; c < MAT_LEN; c++)
				matrix[r][c] = pattern_entry(pattern, r, c);
	end

	assign req_ready = !holding;
	assign rsp_valid = rsp_on;
	assign rsp       = rsp_q;

	// all outputs move on the falling edge
	always @(negedge clk) begin
		if (rsp_hs) begin
			holding = 1'b0;
			rsp_on  = 1'b0;
		end
		if (req_hs) begin
			holding = 1'b1;
			delay   = 1 + int'($unsigned($random(seed)) % 32'd3); // 1 to 3 cycles
		end
		if (holding && !rsp_on) begin
			if (delay <= 1) begin
				rsp_on = 1'b1;
				rsp_q  = read_column(req_q);
			end else begin
				delay = delay - 1;
			end
		end
		req_hs = req_valid && !holding; // seen by the DUT at the next rising edge
		if (req_hs)
			req_q = req;
		rsp_hs = rsp_on && rsp_ready;
	end

endmodule

//--- tests/traceback_tb.sv
module traceback_tb import align_geom_pkg::*, trace_code_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		pos_t       x;
		pos_t       y;
		logic [1:0] pattern;
		logic       bp;    // random sym_ready
		int         count; // expected symbols
	} case_t;

	localparam int NUM_CASES   = 5;
	localparam int FROM_REF    = -1;
	localparam int CYCLE_LIMIT = (NUM_CASES + 1) * 2000; // reset check adds a case

	logic       clk;
	logic       rst_n;
	logic       start_valid;
	logic       start_ready;
	start_req_t start_req;
	logic       mem_req_valid;
	logic       mem_req_ready;
	col_req_t   mem_req;
	logic       mem_rsp_valid;
	logic       mem_rsp_ready;
	column_t    mem_rsp;
	logic       sym_valid;
	logic       sym_ready;
	trace_sym_t sym;
	logic       done;
	logic       busy;
	logic [1:0] pattern;
	case_t      cases [NUM_CASES];
	trace_sym_t expected [$];
	int         seed   = 32'h6d25_f1dc;
	int         cycles = 0;

	traceback_top dut_i (.*);

	dir_memory_model mem_i (
		.clk       (clk),
		.pattern   (pattern),
		.req_valid (mem_req_valid),
		.req_ready (mem_req_ready),
		.req       (mem_req),
		.rsp_valid (mem_rsp_valid),
		.rsp_ready (mem_rsp_ready),
		.rsp       (mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: the traceback run is still going after %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input int actual, input int expect_v);
		if (actual != expect_v) begin
			$display("FAIL %0t %s: got %0d, expected %0d", $time, name, actual, expect_v);
			$display("ERRORS FOUND");
			$fatal(1, "value mismatch");
		end
	endtask

	// expected symbols straight from the memory model's matrix
	task automatic reference_walk(input int sx, input int sy);
		int         x;
		int         y;
		logic       mx;
		logic       my;
		logic       walking;
		dir_entry_t e;
		trace_sym_t s;
		trace_sym_t prev;
		trace_sym_t nprev;
		expected.delete();
		x = sx;
		y = sy;
		prev = M;
		walking = 1'b1;
		while (walking) begin
			e = mem_i.matrix[x][y];
			if (prev == I) begin
				s = I;
				nprev = e.e_ext ? I : M;
			end else if (prev == D) begin
				s = D;
				nprev = e.f_ext ? D : M;
			end else begin
				case (e.h_src)
					H_STOP:  s = STOP;
					H_DIAG:  s = M;
					H_LEFT:  s = I;
					default: s = D;
				endcase
				nprev = s;
			end
			mx = (s == M) || (s == D);
			my = (s == M) || (s == I);
			if (s == STOP || (mx && x == 0) || (my && y == 0)) begin
				walking = 1'b0;
			end else begin
				expected.push_back(s);
				x = mx ? x - 1 : x;
				y = my ? y - 1 : y;
				prev = nprev;
			end
		end
	endtask

	task automatic run_case(input case_t tc);
		int          got;
		logic        finished;
		logic [31:0] rnd;
		pattern = tc.pattern;
		@(negedge clk);
		reference_walk(int'(tc.x), int'(tc.y));
		if (tc.count != FROM_REF)
			check_value("reference symbol count", expected.size(), tc.count);
		check_value("start_ready", int'(start_ready), 1);
		start_valid = 1'b1;
		start_req   = '{x: tc.x, y: tc.y};
		@(negedge clk);
		start_valid = 1'b0;
		check_value("busy", int'(busy), 1);
		got = 0;
		finished = 1'b0;
		while (!finished) begin
			rnd = $random(seed);
			sym_ready = tc.bp ? rnd[0] : 1'b1;
			if (done) begin
				finished = 1'b1;
			end else begin
				if (sym_valid && sym_ready) begin // accepted at the next rising edge
					if (got < expected.size())
						check_value("sym", int'(sym), int'(expected[got]));
					else
						check_value("symbol count", got + 1, expected.size());
					got++;
				end
				@(negedge clk);
			end
		end
		check_value("busy", int'(busy), 0);
		check_value("symbol count", got, expected.size());
		sym_ready = 1'b0;
		@(negedge clk);
		check_value("done", int'(done), 0); // single pulse
	endtask

	initial begin
		rst_n       = 1'b0;
		start_valid = 1'b0;
		start_req   = '0;
		sym_ready   = 1'b0;
		pattern     = 2'd0;
		cases[0] = '{x: 6'd20, y: 6'd13, pattern: 2'd0, bp: 1'b0, count: 13};
		cases[1] = '{x: 6'd5,  y: 6'd40, pattern: 2'd1, bp: 1'b0, count: 40};
		cases[2] = '{x: 6'd30, y: 6'd30, pattern: 2'd2, bp: 1'b0, count: 0};
		cases[3] = '{x: 6'd63, y: 6'd63, pattern: 2'd3, bp: 1'b0, count: FROM_REF};
		cases[4] = '{x: 6'd63, y: 6'd63, pattern: 2'd3, bp: 1'b1, count: FROM_REF};
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("sym_valid", int'(sym_valid), 0);
		check_value("done", int'(done), 0);
		check_value("busy", int'(busy), 0);
		check_value("start_ready", int'(start_ready), 1);
		for (int n = 0; n < NUM_CASES; n++)
			run_case(cases[n]);
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- build.f
logic/align_geom_pkg.sv
logic/trace_code_pkg.sv
logic/column_fetcher.sv
logic/tile_store.sv
logic/traceback_walker.sv
logic/traceback_top.sv
tests/dir_memory_model.sv
tests/traceback_tb.sv

//--- Makefile
TOP := traceback_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module traceback_top

clean:
	rm -rf obj_dir
